//--- verilog/qla_bus_pkg.sv
// host register bus definitions

package qla_bus_pkg;

    // ------------------------------------------------
    // bus widths
    // ------------------------------------------------
    typedef logic [15:0] reg_addr_t;   // host register address
    typedef logic [31:0] reg_data_t;   // host register data word
    typedef logic [3:0]  addr_nib_t;   // one address nibble
    typedef logic [3:0]  board_id_t;   // rotary switch id

    // ------------------------------------------------
    // register map
    // ------------------------------------------------
    // addr[15:12] picks the space
    localparam addr_nib_t ADDR_SPACE_MAIN = 4'h0;

    // addr[7:4] picks the channel, 0 is the board itself
    localparam addr_nib_t CHAN_BOARD = 4'h0;

    // addr[3:0] picks the register within a channel
    localparam addr_nib_t OFF_ADC_DATA = 4'h0;   // feedback sample, board status on chan 0
    localparam addr_nib_t OFF_DAC_CTRL = 4'h1;   // current command
    localparam addr_nib_t OFF_AMP_CTRL = 4'h2;   // amp enable and trip flag

    // board id sits in the top byte of the status word
    localparam int BOARD_ID_LSB = 24;

    // host write, wen high for one cycle per write
    typedef struct packed {
        logic      wen;
        reg_addr_t waddr;
        reg_data_t wdata;
    } reg_wr_t;

endpackage

//--- verilog/qla_axis_pkg.sv
// motor axis definitions

package qla_axis_pkg;

    // ------------------------------------------------
    // axis count and current type
    // ------------------------------------------------
    localparam int NUM_AXES = 4;

    typedef logic [1:0]  axis_idx_t;   // axis 1..4 stored as 0..3
    typedef logic [15:0] cur_t;        // unsigned current code, cmd and fb alike

    // ------------------------------------------------
    // safety check
    // ------------------------------------------------
    // consecutive over-limit samples needed to trip
    localparam int SAFETY_TRIP_COUNT = 4;
    localparam int TRIP_CNT_W = $clog2(SAFETY_TRIP_COUNT) + 1;

    typedef logic [TRIP_CNT_W-1:0] trip_cnt_t;

    typedef enum logic {
        SAFE_ARMED,     // amp may run
        SAFE_TRIPPED    // held off until amp ctrl write
    } safety_state_t;

    // decoded writes for one axis
    typedef struct packed {
        logic dac_wen;
        cur_t dac_data;
        logic amp_wen;
        logic amp_en;
    } axis_wr_t;

    // per axis state for readback
    typedef struct packed {
        cur_t fb_last;
        cur_t cmd;
        logic amp_en;
        logic tripped;
    } axis_status_t;

endpackage

//--- verilog/reg_write_decode.sv
// register write decoder

`timescale 1ns/1ps

module reg_write_decode (
    input  logic                                               sysclk,
    input  logic                                               rst,
    input  qla_bus_pkg::reg_wr_t                               host_wr,
    output qla_axis_pkg::axis_wr_t [qla_axis_pkg::NUM_AXES-1:0] axis_wr
);

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    addr_nib_t wr_space;
    addr_nib_t wr_chan;
    addr_nib_t wr_off;
    logic      chan_ok;
    axis_idx_t wr_axis;
    logic      main_wr;
    logic      dac_hit;
    logic      amp_hit;

    // ------------------------------------------------
    // address split
    // ------------------------------------------------
    assign wr_space = host_wr.waddr[15:12];
    assign wr_chan  = host_wr.waddr[7:4];   // bits 11:8 not decoded
    assign wr_off   = host_wr.waddr[3:0];

    // only channels 1..NUM_AXES are axes
    assign chan_ok = (wr_chan != CHAN_BOARD) && (wr_chan <= addr_nib_t'(NUM_AXES));
    assign wr_axis = axis_idx_t'(wr_chan - 4'd1);   // chan 1 -> axis slot 0

    assign main_wr = host_wr.wen && (wr_space == ADDR_SPACE_MAIN) && chan_ok;
    assign dac_hit = main_wr && (wr_off == OFF_DAC_CTRL);
    assign amp_hit = main_wr && (wr_off == OFF_AMP_CTRL);   // other offsets dropped

    // ------------------------------------------------
    // registered one-hot pulses
    // ------------------------------------------------
    always_ff @(posedge sysclk) begin
        for (int i = 0; i < NUM_AXES; i++) begin
            // data fields follow the bus every cycle
            axis_wr[i].dac_data <= host_wr.wdata[$bits(cur_t)-1:0];
            axis_wr[i].amp_en   <= host_wr.wdata[0];
            if (rst) begin
                axis_wr[i].dac_wen <= 1'b0;
                axis_wr[i].amp_wen <= 1'b0;
            end else begin
                axis_wr[i].dac_wen <= dac_hit && (wr_axis == axis_idx_t'(i));
                axis_wr[i].amp_wen <= amp_hit && (wr_axis == axis_idx_t'(i));
            end
        end
    end

endmodule

//--- verilog/axis_channel.sv
// single motor axis channel

`timescale 1ns/1ps

module axis_channel (
    input  logic                       sysclk,
    input  logic                       rst,
    input  qla_axis_pkg::axis_wr_t     axis_wr,
    input  qla_axis_pkg::cur_t         cur_fb,
    input  logic                       cur_valid,
    output qla_axis_pkg::cur_t         dac_cmd,
    output logic                       amp_disable,
    output qla_axis_pkg::axis_status_t status
);

    import qla_axis_pkg::*;

    cur_t          cmd_q;        // current command
    cur_t          fb_q;         // last feedback sample
    logic          amp_en_q;
    logic          amp_en_d;
    logic          amp_dis_q;
    safety_state_t state_q;
    safety_state_t state_d;
    trip_cnt_t     cnt_q;        // consecutive over-limit samples
    trip_cnt_t     cnt_d;
    logic          over_lim;

    // fb > 2*cmd, both sides at 17 bits
    assign over_lim = {1'b0, cur_fb} > {cmd_q, 1'b0};

    // amp enable only moves on an amp ctrl write
    assign amp_en_d = axis_wr.amp_wen ? axis_wr.amp_en : amp_en_q;

    // ------------------------------------------------
    // safety FSM next state
    // ------------------------------------------------
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        if (axis_wr.amp_wen) begin
            // amp ctrl write rearms, wins over a sample in the same cycle
            state_d = SAFE_ARMED;
            cnt_d   = '0;
        end else begin
            case (state_q)
                SAFE_ARMED: begin
                    if (cur_valid) begin
                        if (!over_lim) begin
                            cnt_d = '0;   // run broken
                        end else if (cnt_q == trip_cnt_t'(SAFETY_TRIP_COUNT - 1)) begin
                            cnt_d   = cnt_q + 1'b1;
                            state_d = SAFE_TRIPPED;
                        end else begin
                            cnt_d = cnt_q + 1'b1;
                        end
                    end
                end
                SAFE_TRIPPED: begin
                    state_d = SAFE_TRIPPED;   // latched
                end
                default: begin
                    state_d = SAFE_ARMED;
                    cnt_d   = '0;
                end
            endcase
        end
    end

    // ------------------------------------------------
    // registers
    // ------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cmd_q     <= '0;
            fb_q      <= '0;
            amp_en_q  <= 1'b0;
            amp_dis_q <= 1'b1;   // amp off out of reset
            state_q   <= SAFE_ARMED;
            cnt_q     <= '0;
        end else begin
            if (axis_wr.dac_wen) begin
                cmd_q <= axis_wr.dac_data;
            end
            if (cur_valid) begin
                fb_q <= cur_fb;
            end
            amp_en_q <= amp_en_d;
            state_q  <= state_d;
            cnt_q    <= cnt_d;
            // from next-state values so a trip shows the same edge
            amp_dis_q <= !amp_en_d || (state_d == SAFE_TRIPPED);
        end
    end

    assign dac_cmd     = cmd_q;
    assign amp_disable = amp_dis_q;

    assign status.fb_last = fb_q;
    assign status.cmd     = cmd_q;
    assign status.amp_en  = amp_en_q;
    assign status.tripped = (state_q == SAFE_TRIPPED);

endmodule

//--- verilog/board_readback.sv
// board status and register readback

`timescale 1ns/1ps

module board_readback (
    input  logic                                                   sysclk,
    input  logic                                                   rst,
    input  qla_bus_pkg::board_id_t                                 board_id,
    input  qla_bus_pkg::reg_addr_t                                 reg_raddr,
    input  qla_axis_pkg::axis_status_t [qla_axis_pkg::NUM_AXES-1:0] axis_status,
    input  logic [qla_axis_pkg::NUM_AXES-1:0]                      amp_disable,
    output qla_bus_pkg::reg_data_t                                 reg_rdata
);

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    addr_nib_t               rd_space;
    addr_nib_t               rd_chan;
    addr_nib_t               rd_off;
    axis_idx_t               rd_axis;
    axis_status_t            sel;          // addressed axis
    logic [NUM_AXES-1:0]     trip_flags;
    reg_data_t               status_word;
    reg_data_t               rd_mux;
    reg_data_t               rdata_q;

    assign rd_space = reg_raddr[15:12];
    assign rd_chan  = reg_raddr[7:4];
    assign rd_off   = reg_raddr[3:0];
    assign rd_axis  = axis_idx_t'(rd_chan - 4'd1);

    // ------------------------------------------------
    // board status word
    // ------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            trip_flags[i] = axis_status[i].tripped;
        end
        status_word = '0;
        status_word[NUM_AXES-1:0]          = amp_disable;   // axis 1 in bit 0
        status_word[2*NUM_AXES-1:NUM_AXES] = trip_flags;
        status_word[BOARD_ID_LSB +: $bits(board_id_t)] = board_id;
    end

    // ------------------------------------------------
    // read mux
    // ------------------------------------------------
    always_comb begin
        sel    = axis_status[rd_axis];
        rd_mux = '0;   // unmapped reads give 0
        if (rd_space == ADDR_SPACE_MAIN) begin
            if (rd_chan == CHAN_BOARD) begin
                if (rd_off == OFF_ADC_DATA) begin
                    rd_mux = status_word;
                end
            end else if (rd_chan <= addr_nib_t'(NUM_AXES)) begin
                case (rd_off)
                    OFF_ADC_DATA: rd_mux = reg_data_t'(sel.fb_last);
                    OFF_DAC_CTRL: rd_mux = reg_data_t'(sel.cmd);
                    OFF_AMP_CTRL: rd_mux = reg_data_t'({sel.tripped, sel.amp_en});
                    default:      rd_mux = '0;
                endcase
            end
        end
    end

    // one cycle read latency
    always_ff @(posedge sysclk) begin
        if (rst) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= rd_mux;
        end
    end

    assign reg_rdata = rdata_q;

endmodule

//--- verilog/qla_board_top.sv
// motor axis board top level

`timescale 1ns/1ps

module qla_board_top (
    input  logic                                           sysclk,
    input  logic                                           rst,
    input  qla_bus_pkg::board_id_t                         board_id,      // static
    input  qla_bus_pkg::reg_wr_t                           host_wr,
    input  qla_bus_pkg::reg_addr_t                         reg_raddr,
    output qla_bus_pkg::reg_data_t                         reg_rdata,
    input  qla_axis_pkg::cur_t [qla_axis_pkg::NUM_AXES-1:0] cur_fb,        // adc samples
    input  logic [qla_axis_pkg::NUM_AXES-1:0]              cur_valid,
    output qla_axis_pkg::cur_t [qla_axis_pkg::NUM_AXES-1:0] dac_cmd,
    output logic [qla_axis_pkg::NUM_AXES-1:0]              amp_disable
);

    import qla_axis_pkg::*;

    axis_wr_t     [NUM_AXES-1:0] axis_wr;       // decoder to channels
    axis_status_t [NUM_AXES-1:0] axis_status;   // channels to readback

    // ------------------------------------------------
    // write decode
    // ------------------------------------------------
    reg_write_decode reg_write_decode_i (
        .sysclk  (sysclk),
        .rst     (rst),
        .host_wr (host_wr),
        .axis_wr (axis_wr)
    );

    // ------------------------------------------------
    // axis channels 1..4
    // ------------------------------------------------
    for (genvar g = 0; g < NUM_AXES; g++) begin : g_axis
        axis_channel axis_channel_i (
            .sysclk      (sysclk),
            .rst         (rst),
            .axis_wr     (axis_wr[g]),
            .cur_fb      (cur_fb[g]),
            .cur_valid   (cur_valid[g]),
            .dac_cmd     (dac_cmd[g]),
            .amp_disable (amp_disable[g]),
            .status      (axis_status[g])
        );
    end

    // ------------------------------------------------
    // readback, status word
    // ------------------------------------------------
    board_readback board_readback_i (
        .sysclk      (sysclk),
        .rst         (rst),
        .board_id    (board_id),
        .reg_raddr   (reg_raddr),
        .axis_status (axis_status),
        .amp_disable (amp_disable),
        .reg_rdata   (reg_rdata)
    );

endmodule

//--- tb/qla_board_checker.sv
// board output checker

`timescale 1ns/1ps

module qla_board_checker (
    input  logic                                            sysclk,
    input  logic                                            chk_en,      // compare on this edge
    input  logic                                            chk_rd,      // read data too
    input  int                                              entry_idx,   // table row, for messages
    input  qla_bus_pkg::reg_data_t                          exp_rdata,
    input  logic [qla_axis_pkg::NUM_AXES-1:0]               exp_amp,
    input  qla_axis_pkg::cur_t [qla_axis_pkg::NUM_AXES-1:0] exp_dac,
    input  qla_bus_pkg::reg_data_t                          reg_rdata,
    input  logic [qla_axis_pkg::NUM_AXES-1:0]               amp_disable,
    input  qla_axis_pkg::cur_t [qla_axis_pkg::NUM_AXES-1:0] dac_cmd,
    output int                                              err_count,
    output int                                              chk_count
);

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    int errs   = 0;
    int checks = 0;

    // ------------------------------------------------
    // compare on the rising edge, outputs settled since the last one
    // ------------------------------------------------
    always @(posedge sysclk) begin
        if (chk_en) begin
            checks = checks + 1;
            if (amp_disable !== exp_amp) begin
                errs = errs + 1;
                $display("CHECK FAILED at %0t ns: row %0d amp_disable %b, expected %b",
                         $time, entry_idx, amp_disable, exp_amp);
            end
            for (int i = 0; i < NUM_AXES; i++) begin
                if (dac_cmd[i] !== exp_dac[i]) begin
                    errs = errs + 1;
                    $display("CHECK FAILED at %0t ns: row %0d dac_cmd axis %0d %h, expected %h",
                             $time, entry_idx, i + 1, dac_cmd[i], exp_dac[i]);
                end
            end
            if (chk_rd && (reg_rdata !== exp_rdata)) begin   // reads only
                errs = errs + 1;
                $display("CHECK FAILED at %0t ns: row %0d reg_rdata %h, expected %h",
                         $time, entry_idx, reg_rdata, exp_rdata);
            end
        end
    end

    assign err_count = errs;
    assign chk_count = checks;

endmodule

//--- tb/tb_qla_board.sv
// motor axis board testbench

`timescale 1ns/1ps

module tb_qla_board;

    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    typedef enum logic [1:0] {K_WR, K_RD, K_SMP, K_RND} kind_t;

    // addr holds the axis index on sample rows
    typedef struct packed {
        kind_t               kind;
        reg_addr_t           addr;
        reg_data_t           data;      // write data, sample or random count
        reg_data_t           exp_rd;
        logic [NUM_AXES-1:0] exp_amp;
    } entry_t;

    localparam board_id_t BOARD_ID = 4'hA;
    localparam reg_data_t ID_WORD  = reg_data_t'(BOARD_ID) << BOARD_ID_LSB;

    logic                sysclk = 1'b0;
    logic                rst;
    reg_wr_t             host_wr;
    reg_addr_t           reg_raddr;
    reg_data_t           reg_rdata;
    cur_t [NUM_AXES-1:0] cur_fb;
    logic [NUM_AXES-1:0] cur_valid;
    cur_t [NUM_AXES-1:0] dac_cmd;
    logic [NUM_AXES-1:0] amp_disable;

    logic                chk_en;
    logic                chk_rd;
    int                  entry_idx;
    reg_data_t           exp_rdata;
    logic [NUM_AXES-1:0] exp_amp;
    cur_t [NUM_AXES-1:0] cmd_model;   // expected dac_cmd
    int                  err_count;
    int                  chk_count;

    entry_t stim_q[$];
    int     seed = 59937;
    int     wd_ns;

    always #10 sysclk = ~sysclk;   // 20 ns

    qla_board_top qla_board_top_i (
        .sysclk      (sysclk),
        .rst         (rst),
        .board_id    (BOARD_ID),
        .host_wr     (host_wr),
        .reg_raddr   (reg_raddr),
        .reg_rdata   (reg_rdata),
        .cur_fb      (cur_fb),
        .cur_valid   (cur_valid),
        .dac_cmd     (dac_cmd),
        .amp_disable (amp_disable)
    );

    qla_board_checker qla_board_checker_i (
        .sysclk      (sysclk),
        .chk_en      (chk_en),
        .chk_rd      (chk_rd),
        .entry_idx   (entry_idx),
        .exp_rdata   (exp_rdata),
        .exp_amp     (exp_amp),
        .exp_dac     (cmd_model),
        .reg_rdata   (reg_rdata),
        .amp_disable (amp_disable),
        .dac_cmd     (dac_cmd),
        .err_count   (err_count),
        .chk_count   (chk_count)
    );

    task automatic add_entry(input kind_t k, input reg_addr_t a, input reg_data_t d,
                             input reg_data_t r, input logic [NUM_AXES-1:0] m);
        stim_q.push_back('{k, a, d, r, m});
    endtask

    // expectations for the next rising edge
    task automatic request_check(input logic with_rd, input reg_data_t r,
                                 input logic [NUM_AXES-1:0] m);
        exp_rdata = r;
        exp_amp   = m;
        chk_rd    = with_rd;
        chk_en    = 1'b1;
        @(negedge sysclk);
        chk_en = 1'b0;
        chk_rd = 1'b0;
    endtask

    task automatic apply_sample(input int ax, input cur_t val, input logic [NUM_AXES-1:0] m);
        cur_fb[ax]    = val;
        cur_valid[ax] = 1'b1;
        @(negedge sysclk);
        cur_valid = '0;
        request_check(1'b0, '0, m);   // trip visible one edge after the strobe
    endtask

    task automatic apply_write(input entry_t e);
        host_wr = '{wen: 1'b1, waddr: e.addr, wdata: e.data};
        @(negedge sysclk);
        host_wr.wen = 1'b0;
        @(negedge sysclk);   // decoder edge then register edge
        // command loads only from main space, axis channel, command offset
        if (e.addr[15:12] == ADDR_SPACE_MAIN && e.addr[7:4] inside {[4'd1:4'd4]}
            && e.addr[3:0] == OFF_DAC_CTRL) begin
            cmd_model[int'(e.addr[7:4]) - 1] = e.data[15:0];
        end
        request_check(1'b0, '0, e.exp_amp);
    endtask

    task automatic apply_random(input int ax, input int count, input logic [NUM_AXES-1:0] m);
        logic [31:0] rnd;
        logic [31:0] bound;
        bound = 32'(cmd_model[ax]) * 32'd2 + 32'd1;   // never above twice the command
        for (int n = 0; n < count; n++) begin
            rnd = $random(seed);
            apply_sample(ax, cur_t'(rnd % bound), m);
        end
    endtask

    initial begin
        entry_t e;
        rst       = 1'b1;
        host_wr   = '0;
        reg_raddr = '0;
        cur_fb    = '0;
        cur_valid = '0;
        chk_en    = 1'b0;
        chk_rd    = 1'b0;
        entry_idx = 0;
        exp_rdata = '0;
        exp_amp   = '1;
        cmd_model = '0;

        // ------------------------------------------------
        // stimulus table
        // ------------------------------------------------
        add_entry(K_RD, 16'h0000, 0, ID_WORD | 32'h0F, 4'hF);   // reset state
        for (int a = 1; a <= NUM_AXES; a++) begin
            for (int o = 0; o <= int'(OFF_AMP_CTRL); o++) begin
                add_entry(K_RD, reg_addr_t'(a * 16 + o), 0, 32'h0, 4'hF);
            end
        end
        add_entry(K_WR, 16'h0011, 32'h1000, 0, 4'hF);   // commands
        add_entry(K_WR, 16'h0021, 32'h0800, 0, 4'hF);
        add_entry(K_WR, 16'h0031, 32'h0400, 0, 4'hF);
        add_entry(K_WR, 16'h0041, 32'hFFFF_0200, 0, 4'hF);   // upper bits dropped
        add_entry(K_RD, 16'h0011, 0, 32'h1000, 4'hF);
        add_entry(K_RD, 16'h0021, 0, 32'h0800, 4'hF);
        add_entry(K_RD, 16'h0031, 0, 32'h0400, 4'hF);
        add_entry(K_RD, 16'h0041, 0, 32'h0200, 4'hF);
        add_entry(K_WR, 16'h0012, 32'h1, 0, 4'hE);      // enables one axis at a time
        add_entry(K_RD, 16'h0012, 0, 32'h1, 4'hE);
        add_entry(K_WR, 16'h0032, 32'h1, 0, 4'hA);
        add_entry(K_WR, 16'h0022, 32'h1, 0, 4'h8);
        add_entry(K_WR, 16'h0042, 32'h1, 0, 4'h0);
        add_entry(K_RD, 16'h0000, 0, ID_WORD, 4'h0);
        add_entry(K_SMP, 16'd0, 32'h1234, 0, 4'h0);     // feedback capture
        add_entry(K_RD, 16'h0010, 0, 32'h1234, 4'h0);
        add_entry(K_SMP, 16'd1, 32'h1000, 0, 4'h0);     // exactly twice is not over
        add_entry(K_RND, 16'd0, 6, 0, 4'h0);
        add_entry(K_RND, 16'd1, 6, 0, 4'h0);
        add_entry(K_RND, 16'd3, 6, 0, 4'h0);
        // axis 2 broken run then a full run
        repeat (3) add_entry(K_SMP, 16'd1, 32'h1001, 0, 4'h0);
        add_entry(K_SMP, 16'd1, 32'h0FFF, 0, 4'h0);
        repeat (3) add_entry(K_SMP, 16'd1, 32'h1001, 0, 4'h0);
        add_entry(K_SMP, 16'd1, 32'h1001, 0, 4'h2);
        add_entry(K_RD, 16'h0022, 0, 32'h3, 4'h2);
        add_entry(K_RD, 16'h0020, 0, 32'h1001, 4'h2);
        repeat (3) add_entry(K_SMP, 16'd3, 32'h0401, 0, 4'h2);   // axis 4 trips too
        add_entry(K_SMP, 16'd3, 32'h0401, 0, 4'hA);
        add_entry(K_RD, 16'h0000, 0, ID_WORD | 32'hAA, 4'hA);
        add_entry(K_WR, 16'h0022, 32'h1, 0, 4'h8);      // rearm with amp enabled
        add_entry(K_RD, 16'h0022, 0, 32'h1, 4'h8);
        add_entry(K_WR, 16'h0042, 32'h0, 0, 4'h8);      // rearm with amp left off
        add_entry(K_RD, 16'h0042, 0, 32'h0, 4'h8);
        add_entry(K_RD, 16'h0000, 0, ID_WORD | 32'h08, 4'h8);
        add_entry(K_RD, 16'h1010, 0, 32'h0, 4'h8);      // ignored accesses
        add_entry(K_RD, 16'hF000, 0, 32'h0, 4'h8);
        add_entry(K_WR, 16'h0001, 32'hFFFF, 0, 4'h8);
        add_entry(K_WR, 16'h0013, 32'hFFFF, 0, 4'h8);
        add_entry(K_WR, 16'h1011, 32'hFFFF, 0, 4'h8);
        add_entry(K_WR, 16'h1012, 32'h0, 0, 4'h8);
        add_entry(K_WR, 16'h0051, 32'hFFFF, 0, 4'h8);
        add_entry(K_RD, 16'h0051, 0, 32'h0, 4'h8);
        add_entry(K_RD, 16'h0011, 0, 32'h1000, 4'h8);
        add_entry(K_RD, 16'h0000, 0, ID_WORD | 32'h08, 4'h8);

        wd_ns = (stim_q.size() * 10 + 8) * 20;
        fork
            begin
                #(wd_ns);
                $display("watchdog: run did not finish within %0d ns, stopping", wd_ns);
                $display("Result: FAILED");
                $finish;
            end
        join_none

        repeat (8) @(negedge sysclk);
        rst = 1'b0;

        // ------------------------------------------------
        // apply rows
        // ------------------------------------------------
        foreach (stim_q[i]) begin
            e         = stim_q[i];
            entry_idx = i;
            case (e.kind)
                K_WR:  apply_write(e);
                K_RD: begin
                    reg_raddr = e.addr;
                    @(negedge sysclk);   // registered read data
                    request_check(1'b1, e.exp_rd, e.exp_amp);
                end
                K_SMP: apply_sample(int'(e.addr[1:0]), e.data[15:0], e.exp_amp);
                default: apply_random(int'(e.addr[1:0]), int'(e.data), e.exp_amp);
            endcase
        end

        @(negedge sysclk);
        $display("checks run: %0d, errors: %0d", chk_count, err_count);
        if (err_count == 0 && chk_count > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
verilog/qla_bus_pkg.sv
verilog/qla_axis_pkg.sv
verilog/reg_write_decode.sv
verilog/axis_channel.sv
verilog/board_readback.sv
verilog/qla_board_top.sv
tb/qla_board_checker.sv
tb/tb_qla_board.sv

//--- Makefile
# Verilator simulation of the motor axis board

TOP = tb_qla_board

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build and run the testbench with Verilator"
	@echo "  make clean  remove the build directory"
	@echo "  make help   show this list"

test:
	verilator --binary --timing -Wno-fatal -Mdir obj_dir --top-module $(TOP) -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
